// File: common/smem_queue_pkg.sv
`default_nettype none

package smem_queue_pkg;

	// ==============================
	// depths and latencies
	// ==============================
	localparam int QUERY_LAT = 3; // query RAM read latency
	localparam int RING_AW = 6; // 64 parked reads
	localparam int OCC_AW = 5; // 32 occurrence words

	// ==============================
	// field types
	// ==============================
	typedef logic [9:0] read_num_t;
	typedef logic [32:0] bwt_idx_t; // one of x0, x1, x2
	typedef logic [6:0] pos_t; // forward_i, min_intv
	typedef logic [7:0] query_t; // encoded base
	typedef logic [127:0] occ_t; // four 32-bit counts

	// one-hot, bubble is all zero
	typedef enum logic [5:0] {
		st_bubble = 6'b00_0000,
		st_f_init = 6'b00_0001,
		st_f_run = 6'b00_0010,
		st_f_break = 6'b00_0100
	} fwd_status_e;

	// {read_num, x0, x1, x2, forward_i, min_intv, query, status}, 137 bits
	typedef logic [$bits(read_num_t) + 3 * $bits(bwt_idx_t) + 2 * $bits(pos_t)
		+ $bits(query_t) + $bits(fwd_status_e) - 1:0] fwd_entry_t;

endpackage

`default_nettype wire

// File: smem_queue/query_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module query_delay_line (
	input wire Clk_32UI,
	input wire reset_n,
	input wire stall,
	input wire smem_queue_pkg::fwd_status_e fwd_status,
	input wire smem_queue_pkg::read_num_t fwd_read_num,
	input wire smem_queue_pkg::bwt_idx_t fwd_ik_x0,
	input wire smem_queue_pkg::bwt_idx_t fwd_ik_x1,
	input wire smem_queue_pkg::bwt_idx_t fwd_ik_x2,
	input wire smem_queue_pkg::pos_t fwd_forward_i,
	input wire smem_queue_pkg::pos_t fwd_min_intv,
	input wire smem_queue_pkg::query_t query_base,
	output smem_queue_pkg::fwd_entry_t entry,
	output logic entry_valid
);
	import smem_queue_pkg::*;

	// wait stages, one per cycle of query RAM latency
	fwd_status_e st_d [QUERY_LAT];
	read_num_t rn_d [QUERY_LAT];
	bwt_idx_t x0_d [QUERY_LAT];
	bwt_idx_t x1_d [QUERY_LAT];
	bwt_idx_t x2_d [QUERY_LAT];
	pos_t fi_d [QUERY_LAT];
	pos_t mi_d [QUERY_LAT];

	// pack stage, everything but the status
	logic [$bits(fwd_entry_t) - $bits(fwd_status_e) - 1:0] pack_data;
	fwd_status_e pack_status;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			for (int i = 0; i < QUERY_LAT; i++)
				st_d[i] <= st_bubble;
			pack_status <= st_bubble;
		end else if (!stall) begin
			st_d[0] <= fwd_status;
			for (int i = 1; i < QUERY_LAT; i++)
				st_d[i] <= st_d[i - 1];
			pack_status <= st_d[QUERY_LAT - 1];
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			rn_d[0] <= fwd_read_num;
			x0_d[0] <= fwd_ik_x0;
			x1_d[0] <= fwd_ik_x1;
			x2_d[0] <= fwd_ik_x2;
			fi_d[0] <= fwd_forward_i;
			mi_d[0] <= fwd_min_intv;
			for (int i = 1; i < QUERY_LAT; i++) begin
				rn_d[i] <= rn_d[i - 1];
				x0_d[i] <= x0_d[i - 1];
				x1_d[i] <= x1_d[i - 1];
				x2_d[i] <= x2_d[i - 1];
				fi_d[i] <= fi_d[i - 1];
				mi_d[i] <= mi_d[i - 1];
			end
			// query base arrives from the RAM here
			pack_data <= {rn_d[QUERY_LAT - 1], x0_d[QUERY_LAT - 1], x1_d[QUERY_LAT - 1],
				x2_d[QUERY_LAT - 1], fi_d[QUERY_LAT - 1], mi_d[QUERY_LAT - 1], query_base};
		end
	end

	assign entry = {pack_data, pack_status};
	assign entry_valid = (pack_status != st_bubble);

endmodule

`default_nettype wire

// File: smem_queue/read_ring.sv
`timescale 1ns/1ps
`default_nettype none

module read_ring (
	input wire Clk_32UI,
	input wire reset_n,
	input wire stall,
	input wire smem_queue_pkg::fwd_entry_t entry,
	input wire entry_valid,
	input wire pop,
	output smem_queue_pkg::fwd_entry_t head,
	output smem_queue_pkg::fwd_status_e head_status,
	output logic not_empty
);
	import smem_queue_pkg::*;

	fwd_entry_t ring_mem [2 ** RING_AW];
	logic [RING_AW:0] wr_ptr; // msb is the wrap bit
	logic [RING_AW:0] rd_ptr;
	logic full;
	logic push;

	assign push = entry_valid && !stall;
	assign full = (wr_ptr[RING_AW] != rd_ptr[RING_AW])
		&& (wr_ptr[RING_AW - 1:0] == rd_ptr[RING_AW - 1:0]);

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop) // dispatcher only pops when unstalled
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (push)
			ring_mem[wr_ptr[RING_AW - 1:0]] <= entry;
	end

	assign not_empty = (wr_ptr != rd_ptr);
	assign head = ring_mem[rd_ptr[RING_AW - 1:0]];
	// status sits in the low bits of the entry
	assign head_status = not_empty ? fwd_status_e'(head[$bits(fwd_status_e) - 1:0]) : st_bubble;

	// no back-pressure to the forward pipeline, so a full ring is a lost read
	a_ring_no_overflow: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		push |-> !full)
		else $error("read ring overflow");

	a_ring_no_underflow: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		pop |-> not_empty)
		else $error("read ring popped while empty");

endmodule

`default_nettype wire

// File: smem_queue/occ_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module occ_fifo (
	input wire Clk_32UI,
	input wire reset_n,
	input wire dram_get,
	input wire smem_queue_pkg::occ_t occ_in,
	input wire occ_pop,
	output smem_queue_pkg::occ_t occ_head,
	output logic occ_valid
);
	import smem_queue_pkg::*;

	occ_t occ_mem [2 ** OCC_AW];
	logic [OCC_AW:0] wr_ptr;
	logic [OCC_AW:0] rd_ptr;
	logic full;

	assign full = (wr_ptr[OCC_AW] != rd_ptr[OCC_AW])
		&& (wr_ptr[OCC_AW - 1:0] == rd_ptr[OCC_AW - 1:0]);

	// DRAM side keeps writing through stall
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (dram_get)
				wr_ptr <= wr_ptr + 1'b1;
			if (occ_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (dram_get)
			occ_mem[wr_ptr[OCC_AW - 1:0]] <= occ_in;
	end

	assign occ_valid = (wr_ptr != rd_ptr);
	assign occ_head = occ_mem[rd_ptr[OCC_AW - 1:0]];

	a_occ_no_overflow: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		dram_get |-> !full)
		else $error("occurrence FIFO overflow");

	a_occ_no_underflow: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		occ_pop |-> occ_valid)
		else $error("occurrence FIFO popped while empty");

endmodule

`default_nettype wire

// File: smem_queue/queue_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module queue_dispatch (
	input wire Clk_32UI,
	input wire reset_n,
	input wire stall,
	input wire smem_queue_pkg::fwd_entry_t head,
	input wire smem_queue_pkg::fwd_status_e head_status,
	input wire not_empty,
	input wire smem_queue_pkg::occ_t occ_head,
	input wire occ_valid,
	input wire new_read_valid,
	input wire smem_queue_pkg::read_num_t new_read_num,
	input wire smem_queue_pkg::bwt_idx_t new_ik_x0,
	input wire smem_queue_pkg::bwt_idx_t new_ik_x1,
	input wire smem_queue_pkg::bwt_idx_t new_ik_x2,
	input wire smem_queue_pkg::pos_t new_forward_i,
	input wire smem_queue_pkg::pos_t new_min_intv,
	output logic pop,
	output logic occ_pop,
	output logic new_read,
	output smem_queue_pkg::fwd_status_e status_out,
	output smem_queue_pkg::read_num_t read_num_out,
	output smem_queue_pkg::bwt_idx_t ik_x0_out,
	output smem_queue_pkg::bwt_idx_t ik_x1_out,
	output smem_queue_pkg::bwt_idx_t ik_x2_out,
	output smem_queue_pkg::pos_t forward_i_out,
	output smem_queue_pkg::pos_t min_intv_out,
	output smem_queue_pkg::query_t query_out,
	output smem_queue_pkg::occ_t occ_out,
	output smem_queue_pkg::bwt_idx_t forward_k_temp,
	output smem_queue_pkg::bwt_idx_t forward_l_temp
);
	import smem_queue_pkg::*;

	logic bubble_flag; // forces one empty slot after each dispatch
	logic go;
	logic take_break;
	logic take_occ;

	read_num_t h_read_num;
	bwt_idx_t h_x0;
	bwt_idx_t h_x1;
	bwt_idx_t h_x2;
	pos_t h_forward_i;
	pos_t h_min_intv;
	query_t h_query;

	fwd_status_e nxt_status;
	read_num_t nxt_read_num;
	bwt_idx_t nxt_x0;
	bwt_idx_t nxt_x1;
	bwt_idx_t nxt_x2;
	pos_t nxt_forward_i;
	pos_t nxt_min_intv;
	query_t nxt_query;
	occ_t nxt_occ;
	bwt_idx_t nxt_k_temp;
	bwt_idx_t nxt_l_temp;

	// stored status comes through head_status
	assign {h_read_num, h_x0, h_x1, h_x2, h_forward_i, h_min_intv, h_query} =
		head[$bits(fwd_entry_t) - 1:$bits(fwd_status_e)];

	// ==============================
	// pop decision
	// ==============================
	assign go = !stall && !bubble_flag;
	assign take_break = (head_status == st_f_break);
	assign take_occ = !take_break && !new_read_valid && occ_valid && not_empty;

	assign pop = go && (take_break || take_occ);
	assign occ_pop = go && take_occ;
	assign new_read = go && !take_break && new_read_valid;

	always_comb begin
		nxt_status = st_bubble;
		nxt_read_num = h_read_num;
		nxt_x0 = h_x0;
		nxt_x1 = h_x1;
		nxt_x2 = h_x2;
		nxt_forward_i = h_forward_i;
		nxt_min_intv = h_min_intv;
		nxt_query = h_query;
		nxt_occ = '0;
		if (take_break) begin
			nxt_status = st_f_break; // leaves without a memory response
		end else if (new_read_valid) begin
			nxt_status = st_f_init;
			nxt_read_num = new_read_num;
			nxt_x0 = new_ik_x0;
			nxt_x1 = new_ik_x1;
			nxt_x2 = new_ik_x2;
			nxt_forward_i = pos_t'(new_forward_i + 1'b1);
			nxt_min_intv = new_min_intv;
			nxt_query = '0; // first round needs no query
		end else if (take_occ) begin
			nxt_status = head_status;
			nxt_occ = occ_head;
		end
	end

	assign nxt_k_temp = bwt_idx_t'(nxt_x1 - 1'b1);
	assign nxt_l_temp = bwt_idx_t'(nxt_k_temp + nxt_x2);

	// ==============================
	// output registers
	// ==============================
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			status_out <= st_bubble;
			bubble_flag <= 1'b0;
		end else if (!stall) begin
			if (bubble_flag) begin
				status_out <= st_bubble;
				bubble_flag <= 1'b0;
			end else begin
				status_out <= nxt_status;
				bubble_flag <= (nxt_status != st_bubble);
			end
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (go) begin
			read_num_out <= nxt_read_num;
			ik_x0_out <= nxt_x0;
			ik_x1_out <= nxt_x1;
			ik_x2_out <= nxt_x2;
			forward_i_out <= nxt_forward_i;
			min_intv_out <= nxt_min_intv;
			query_out <= nxt_query;
			occ_out <= nxt_occ;
			forward_k_temp <= nxt_k_temp;
			forward_l_temp <= nxt_l_temp;
		end
	end

	// every result is followed by an empty slot
	a_bubble_after_result: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		(status_out != st_bubble) && !stall |=> status_out == st_bubble)
		else $error("no bubble after a dispatched result");

endmodule

`default_nettype wire

// File: smem_queue/smem_queue.sv
`timescale 1ns/1ps
`default_nettype none

module smem_queue (
	input wire Clk_32UI,
	input wire reset_n,
	input wire stall,

	// forward pipeline return
	input wire smem_queue_pkg::fwd_status_e fwd_status,
	input wire smem_queue_pkg::read_num_t fwd_read_num,
	input wire smem_queue_pkg::bwt_idx_t fwd_ik_x0,
	input wire smem_queue_pkg::bwt_idx_t fwd_ik_x1,
	input wire smem_queue_pkg::bwt_idx_t fwd_ik_x2,
	input wire smem_queue_pkg::pos_t fwd_forward_i,
	input wire smem_queue_pkg::pos_t fwd_min_intv,

	// query RAM request and reply
	input wire smem_queue_pkg::pos_t next_query_position,
	input wire smem_queue_pkg::read_num_t read_num_query,
	input wire smem_queue_pkg::fwd_status_e status_query,
	output smem_queue_pkg::pos_t query_position,
	output smem_queue_pkg::read_num_t query_read_num,
	output smem_queue_pkg::fwd_status_e query_status,
	input wire smem_queue_pkg::query_t query_base,

	// DRAM occurrence words
	input wire dram_get,
	input wire smem_queue_pkg::occ_t occ_in,

	// read loader
	input wire new_read_valid,
	input wire smem_queue_pkg::read_num_t new_read_num,
	input wire smem_queue_pkg::bwt_idx_t new_ik_x0,
	input wire smem_queue_pkg::bwt_idx_t new_ik_x1,
	input wire smem_queue_pkg::bwt_idx_t new_ik_x2,
	input wire smem_queue_pkg::pos_t new_forward_i,
	input wire smem_queue_pkg::pos_t new_min_intv,
	output logic new_read,

	// results to forward pipeline
	output smem_queue_pkg::fwd_status_e status_out,
	output smem_queue_pkg::read_num_t read_num_out,
	output smem_queue_pkg::bwt_idx_t ik_x0_out,
	output smem_queue_pkg::bwt_idx_t ik_x1_out,
	output smem_queue_pkg::bwt_idx_t ik_x2_out,
	output smem_queue_pkg::pos_t forward_i_out,
	output smem_queue_pkg::pos_t min_intv_out,
	output smem_queue_pkg::query_t query_out,
	output smem_queue_pkg::occ_t occ_out,
	output smem_queue_pkg::bwt_idx_t forward_k_temp,
	output smem_queue_pkg::bwt_idx_t forward_l_temp
);
	import smem_queue_pkg::*;

	fwd_entry_t entry;
	logic entry_valid;
	fwd_entry_t head;
	fwd_status_e head_status;
	logic not_empty;
	logic pop;
	occ_t occ_head;
	logic occ_valid;
	logic occ_pop;

	// query request goes straight to the read RAM
	assign query_position = next_query_position;
	assign query_read_num = read_num_query;
	assign query_status = status_query;

	query_delay_line u_delay (
		.Clk_32UI(Clk_32UI), .reset_n(reset_n), .stall(stall),
		.fwd_status(fwd_status), .fwd_read_num(fwd_read_num),
		.fwd_ik_x0(fwd_ik_x0), .fwd_ik_x1(fwd_ik_x1), .fwd_ik_x2(fwd_ik_x2),
		.fwd_forward_i(fwd_forward_i), .fwd_min_intv(fwd_min_intv),
		.query_base(query_base), .entry(entry), .entry_valid(entry_valid)
	);

	read_ring u_ring (
		.Clk_32UI(Clk_32UI), .reset_n(reset_n), .stall(stall),
		.entry(entry), .entry_valid(entry_valid), .pop(pop),
		.head(head), .head_status(head_status), .not_empty(not_empty)
	);

	occ_fifo u_occ (
		.Clk_32UI(Clk_32UI), .reset_n(reset_n), .dram_get(dram_get),
		.occ_in(occ_in), .occ_pop(occ_pop),
		.occ_head(occ_head), .occ_valid(occ_valid)
	);

	queue_dispatch u_dispatch (
		.Clk_32UI(Clk_32UI), .reset_n(reset_n), .stall(stall),
		.head(head), .head_status(head_status), .not_empty(not_empty),
		.occ_head(occ_head), .occ_valid(occ_valid),
		.new_read_valid(new_read_valid), .new_read_num(new_read_num),
		.new_ik_x0(new_ik_x0), .new_ik_x1(new_ik_x1), .new_ik_x2(new_ik_x2),
		.new_forward_i(new_forward_i), .new_min_intv(new_min_intv),
		.pop(pop), .occ_pop(occ_pop), .new_read(new_read),
		.status_out(status_out), .read_num_out(read_num_out),
		.ik_x0_out(ik_x0_out), .ik_x1_out(ik_x1_out), .ik_x2_out(ik_x2_out),
		.forward_i_out(forward_i_out), .min_intv_out(min_intv_out),
		.query_out(query_out), .occ_out(occ_out),
		.forward_k_temp(forward_k_temp), .forward_l_temp(forward_l_temp)
	);

endmodule

`default_nettype wire

// File: tests/smem_queue_model.svh
`ifndef SMEM_QUEUE_MODEL_SVH
`define SMEM_QUEUE_MODEL_SVH

// ==============================
// random numbers
// ==============================
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// expected result bus, same field order as the DUT outputs
typedef logic [$bits(fwd_status_e) + $bits(read_num_t) + 5 * $bits(bwt_idx_t)
	+ 2 * $bits(pos_t) + $bits(query_t) + $bits(occ_t) - 1:0] result_t;

// ==============================
// reference dispatch
// ==============================
function automatic result_t expected_result(input fwd_entry_t src, input occ_t word,
	input logic is_init);
	read_num_t rn;
	bwt_idx_t x0, x1, x2;
	bwt_idx_t k, l;
	pos_t fi, mi;
	query_t q;
	logic [$bits(fwd_status_e) - 1:0] st;
	occ_t w;
	{rn, x0, x1, x2, fi, mi, q, st} = src;
	w = '0;
	if (is_init) begin
		st = st_f_init; // fresh read from the loader
		fi = fi + 1'b1; // wraps at 7 bits
		q = '0;
	end else if (st == st_f_run) begin
		w = word; // break leaves without a word
	end
	k = x1 - 1'b1;
	l = k + x2;
	return {st, rn, x0, x1, x2, fi, mi, q, w, k, l};
endfunction

task automatic check_value(input string name, input logic [511:0] got,
	input logic [511:0] exp);
	if (got !== exp) begin
		$display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		abort_run("output mismatch");
	end
endtask

`endif

// File: tests/smem_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module smem_queue_tb;
	import smem_queue_pkg::*;

	logic Clk_32UI;
	logic reset_n;
	logic stall;
	fwd_status_e fwd_status;
	read_num_t fwd_read_num;
	bwt_idx_t fwd_ik_x0, fwd_ik_x1, fwd_ik_x2;
	pos_t fwd_forward_i, fwd_min_intv;
	pos_t next_query_position, query_position;
	read_num_t read_num_query, query_read_num;
	fwd_status_e status_query, query_status;
	query_t query_base;
	logic dram_get;
	occ_t occ_in;
	logic new_read_valid;
	logic new_read;
	read_num_t new_read_num;
	bwt_idx_t new_ik_x0, new_ik_x1, new_ik_x2;
	pos_t new_forward_i, new_min_intv;
	fwd_status_e status_out;
	read_num_t read_num_out;
	bwt_idx_t ik_x0_out, ik_x1_out, ik_x2_out;
	pos_t forward_i_out, min_intv_out;
	query_t query_out;
	occ_t occ_out;
	bwt_idx_t forward_k_temp, forward_l_temp;

	logic [31:0] rng_state;
	fwd_entry_t fwd_q[$]; // accepted forward items, ring order
	fwd_entry_t init_q[$]; // reads taken from the loader
	occ_t occ_q[$]; // words in DRAM arrival order
	query_t qpipe[QUERY_LAT]; // bases on their way through the query RAM
	query_t cur_base; // base for the item now on fwd_status
	int new_left;

	smem_queue u_dut (.*);

	always #50 Clk_32UI = ~Clk_32UI;

	`include "smem_queue_model.svh"

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic bwt_idx_t rand_idx();
		logic [31:0] hi;
		hi = next_rand();
		return {hi[0], next_rand()};
	endfunction

	task automatic load_next_read();
		if (new_left > 0) begin
			new_left--;
			new_read_valid = 1'b1;
			new_read_num = read_num_t'(next_rand());
			new_ik_x0 = rand_idx();
			new_ik_x1 = rand_idx();
			new_ik_x2 = rand_idx();
			new_forward_i = pos_t'(next_rand());
			new_min_intv = pos_t'(next_rand());
		end else begin
			new_read_valid = 1'b0;
		end
	endtask

	// ==============================
	// one clock cycle
	// ==============================
	task automatic tick();
		logic took_read;
		logic was_stalled;
		@(negedge Clk_32UI);
		took_read = new_read; // settled, holds until the edge
		was_stalled = stall;
		@(posedge Clk_32UI);
		#1;
		if (dram_get)
			occ_q.push_back(occ_in); // FIFO takes words through stall
		if (!was_stalled) begin
			if (fwd_status != st_bubble)
				fwd_q.push_back({fwd_read_num, fwd_ik_x0, fwd_ik_x1, fwd_ik_x2,
					fwd_forward_i, fwd_min_intv, cur_base, fwd_status});
			for (int i = QUERY_LAT - 1; i > 0; i--)
				qpipe[i] = qpipe[i - 1];
			qpipe[0] = cur_base;
		end
		if (took_read) begin
			init_q.push_back({new_read_num, new_ik_x0, new_ik_x1, new_ik_x2,
				new_forward_i, new_min_intv, query_t'(0), st_f_init});
			load_next_read();
		end
		query_base = qpipe[QUERY_LAT - 1]; // sampled QUERY_LAT edges after accept
		fwd_status = st_bubble;
		cur_base = '0;
		dram_get = 1'b0;
	endtask

	task automatic present_fwd(input fwd_status_e st);
		fwd_status = st;
		fwd_read_num = read_num_t'(next_rand());
		fwd_ik_x0 = rand_idx();
		fwd_ik_x1 = rand_idx();
		fwd_ik_x2 = rand_idx();
		fwd_forward_i = pos_t'(next_rand());
		fwd_min_intv = pos_t'(next_rand());
		cur_base = query_t'(next_rand());
		tick();
	endtask

	task automatic push_occ();
		dram_get = 1'b1;
		occ_in = {next_rand(), next_rand(), next_rand(), next_rand()};
		tick();
	endtask

	task automatic wait_drained(input int limit, input string what);
		int n;
		n = 0;
		while (fwd_q.size() != 0 || init_q.size() != 0 || occ_q.size() != 0
			|| new_read_valid) begin
			if (n == limit) begin
				abort_run({"timeout while waiting for ", what});
			end else begin
				tick();
				n++;
			end
		end
	endtask

	// ==============================
	// compare process
	// ==============================
	initial begin : compare_results
		logic in_reset;
		logic frozen;
		logic last_busy;
		result_t got, last, exp;
		fwd_entry_t src;
		occ_t word;
		logic [$bits(fwd_status_e) - 1:0] e_st;
		read_num_t e_rn;
		bwt_idx_t e_x0, e_x1, e_x2, e_k, e_l;
		pos_t e_fi, e_mi;
		query_t e_q;
		occ_t e_occ;
		last_busy = 1'b0;
		last = '0;
		forever begin
			@(posedge Clk_32UI);
			in_reset = !reset_n;
			frozen = stall;
			@(negedge Clk_32UI);
			got = {status_out, read_num_out, ik_x0_out, ik_x1_out, ik_x2_out, forward_i_out,
				min_intv_out, query_out, occ_out, forward_k_temp, forward_l_temp};
			if (stall)
				check_value("new_read", new_read, 1'b0);
			if (in_reset) begin
				last_busy = 1'b0;
			end else if (frozen) begin
				check_value("held outputs", got, last);
			end else if (status_out != st_bubble) begin
				if (last_busy)
					abort_run("two results with no bubble cycle between them");
				word = '0;
				if (status_out == st_f_init) begin
					if (init_q.size() == 0)
						abort_run("st_f_init result without a new read taken");
					exp = expected_result(init_q.pop_front(), word, 1'b1);
				end else begin
					if (fwd_q.size() == 0)
						abort_run("forward result without an accepted item");
					src = fwd_q.pop_front();
					if (src[$bits(fwd_status_e) - 1:0] == st_f_run) begin
						if (occ_q.size() == 0)
							abort_run("st_f_run result without a pending word");
						word = occ_q.pop_front();
					end
					exp = expected_result(src, word, 1'b0);
				end
				{e_st, e_rn, e_x0, e_x1, e_x2, e_fi, e_mi, e_q, e_occ, e_k, e_l} = exp;
				check_value("status_out", status_out, e_st);
				check_value("read_num_out", read_num_out, e_rn);
				check_value("ik_x0_out", ik_x0_out, e_x0);
				check_value("ik_x1_out", ik_x1_out, e_x1);
				check_value("ik_x2_out", ik_x2_out, e_x2);
				check_value("forward_i_out", forward_i_out, e_fi);
				check_value("min_intv_out", min_intv_out, e_mi);
				check_value("query_out", query_out, e_q);
				check_value("occ_out", occ_out, e_occ);
				check_value("forward_k_temp", forward_k_temp, e_k);
				check_value("forward_l_temp", forward_l_temp, e_l);
			end
			if (!in_reset && !frozen)
				last_busy = (status_out != st_bubble);
			last = got;
		end
	end

	// ==============================
	// scenarios
	// ==============================
	initial begin
		Clk_32UI = 1'b0;
		reset_n = 1'b0;
		stall = 1'b0;
		rng_state = 32'h1359_68b2;
		fwd_status = st_bubble;
		{fwd_read_num, fwd_ik_x0, fwd_ik_x1, fwd_ik_x2, fwd_forward_i, fwd_min_intv} = '0;
		next_query_position = '0;
		read_num_query = '0;
		status_query = st_bubble;
		query_base = '0;
		dram_get = 1'b0;
		occ_in = '0;
		new_read_valid = 1'b0;
		{new_read_num, new_ik_x0, new_ik_x1, new_ik_x2, new_forward_i, new_min_intv} = '0;
		new_left = 0;
		cur_base = '0;
		for (int i = 0; i < QUERY_LAT; i++)
			qpipe[i] = '0;
		repeat (4) tick();
		reset_n = 1'b1;

		// idle after reset, query request passes straight through
		next_query_position = pos_t'(next_rand());
		read_num_query = read_num_t'(next_rand());
		status_query = st_f_run;
		tick();
		check_value("status_out", status_out, st_bubble);
		check_value("new_read", new_read, 1'b0);
		check_value("query_position", query_position, next_query_position);
		check_value("query_read_num", query_read_num, read_num_query);
		check_value("query_status", query_status, status_query);

		new_left = 3; // loader reads into an empty ring
		load_next_read();
		wait_drained(40, "new reads");

		repeat (5) present_fwd(st_f_run);
		repeat (3) tick();
		repeat (5) push_occ();
		wait_drained(80, "forward items");

		push_occ(); // break must leave this word for the run item
		present_fwd(st_f_break);
		present_fwd(st_f_run);
		wait_drained(60, "break and run items");

		repeat (4) present_fwd(st_f_run);
		repeat (2) push_occ();
		repeat (4) tick();
		stall = 1'b1;
		new_left = 1; // loader waits out the stall
		load_next_read();
		repeat (2) push_occ();
		repeat (3) tick();
		stall = 1'b0;
		wait_drained(80, "items after stall");

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: smem_queue.f
+incdir+tests
common/smem_queue_pkg.sv
smem_queue/query_delay_line.sv
smem_queue/read_ring.sv
smem_queue/occ_fifo.sv
smem_queue/queue_dispatch.sv
smem_queue/smem_queue.sv
tests/smem_queue_tb.sv
